// ==== Makefile ====
# Verilator build and run for the crypto ISE coprocessor core

VERILATOR ?= verilator
TOP       ?= tb_ise
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/ise_cop_top.sv ====
/*
 * Crypto ISE coprocessor core
 *   Decode, CPR file, execute and result registers
 *   Single stage, one instruction per cycle
 */
module ise_cop_top
    import ise_pkg::*;
#(
    parameter word_t CPR_RESET_VALUE = '0 // Reset value of every CPR
)
(
    input  logic      g_clk,            // Clock
    input  logic      g_resetn,         // Synchronous active low reset

    input  logic      cop_insn_valid,   // Instruction valid
    input  word_t     cop_insn_enc,     // Encoded instruction
    input  word_t     cop_rs1,          // GPR source data

    output result_t   cop_result,       // Instruction result
    output cpr_mask_t cop_cprs_read,    // CPRs read
    output cpr_mask_t cop_cprs_written, // CPRs written
    output logic      cop_rd_wen,       // GPR write enable
    output gpr_addr_t cop_rd_addr,      // GPR write index
    output word_t     cop_rd_data       // GPR write data
);

    // Decoded fields
    op_t       op;
    cpr_addr_t crd;
    cpr_addr_t crs1;
    cpr_addr_t crs2;
    gpr_addr_t rd;
    imm16_t    imm16;

    // CPR read data
    word_t     rdata_a;
    word_t     rdata_b;
    word_t     rdata_c;

    // CPR write port
    logic      cpr_wen;
    cpr_addr_t cpr_waddr;
    word_t     cpr_wdata;

    // Next result values
    logic      gpr_wen;
    gpr_addr_t gpr_addr;
    word_t     gpr_data;
    cpr_mask_t read_mask;
    cpr_mask_t written_mask;
    result_t   result;

    // ------------------------------------------------------------------------

    ise_decode u_decode (
        .cop_insn_valid (cop_insn_valid),
        .cop_insn_enc   (cop_insn_enc),
        .op             (op),
        .crd            (crd),
        .crs1           (crs1),
        .crs2           (crs2),
        .rd             (rd),
        .imm16          (imm16)
    );

    ise_cpr_file #(
        .CPR_RESET_VALUE (CPR_RESET_VALUE)
    ) u_cpr_file (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .raddr_a  (crs1),
        .raddr_b  (crs2),
        .raddr_c  (crd),
        .rdata_a  (rdata_a),
        .rdata_b  (rdata_b),
        .rdata_c  (rdata_c),
        .wen      (cpr_wen),
        .waddr    (cpr_waddr),
        .wdata    (cpr_wdata)
    );

    ise_execute u_execute (
        .op           (op),
        .crd          (crd),
        .crs1         (crs1),
        .crs2         (crs2),
        .rd           (rd),
        .imm16        (imm16),
        .cop_rs1      (cop_rs1),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b),
        .rdata_c      (rdata_c),
        .cpr_wen      (cpr_wen),
        .cpr_waddr    (cpr_waddr),
        .cpr_wdata    (cpr_wdata),
        .gpr_wen      (gpr_wen),
        .gpr_addr     (gpr_addr),
        .gpr_data     (gpr_data),
        .read_mask    (read_mask),
        .written_mask (written_mask),
        .result       (result)
    );

    ise_writeback u_writeback (
        .g_clk            (g_clk),
        .g_resetn         (g_resetn),
        .cop_insn_valid   (cop_insn_valid),
        .gpr_wen          (gpr_wen),
        .gpr_addr         (gpr_addr),
        .gpr_data         (gpr_data),
        .read_mask        (read_mask),
        .written_mask     (written_mask),
        .result           (result),
        .cop_result       (cop_result),
        .cop_cprs_read    (cop_cprs_read),
        .cop_cprs_written (cop_cprs_written),
        .cop_rd_wen       (cop_rd_wen),
        .cop_rd_addr      (cop_rd_addr),
        .cop_rd_data      (cop_rd_data)
    );

endmodule

// ==== rtl/ise_cpr_file.sv ====
/*
 * Coprocessor register file
 *   16 x 32-bit architectural CPRs
 *   Three combinational read ports, one synchronous write port
 */
module ise_cpr_file
    import ise_pkg::*;
#(
    parameter word_t CPR_RESET_VALUE = '0 // Value of every CPR after reset
)
(
    input  logic      g_clk,    // Clock
    input  logic      g_resetn, // Synchronous active low reset

    input  cpr_addr_t raddr_a,  // Read port A, crs1
    input  cpr_addr_t raddr_b,  // Read port B, crs2
    input  cpr_addr_t raddr_c,  // Read port C, crd
    output word_t     rdata_a,
    output word_t     rdata_b,
    output word_t     rdata_c,

    input  logic      wen,      // Write enable
    input  cpr_addr_t waddr,    // Write index
    input  word_t     wdata     // Write data
);

    word_t cprs [NUM_CPRS];

    // ------------------------------------------------------------------------
    // Write port

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            for (int i = 0; i < NUM_CPRS; i++)
            begin
                cprs[i] <= CPR_RESET_VALUE;
            end
        end
        else if (wen)
        begin
            cprs[waddr] <= wdata; // Visible to the next instruction
        end
    end

    // Read ports
    assign rdata_a = cprs[raddr_a];
    assign rdata_b = cprs[raddr_b];
    assign rdata_c = cprs[raddr_c]; // Old crd value for half-word merges

endmodule

// ==== rtl/ise_decode.sv ====
/*
 * Instruction decoder
 *   Splits the encoded word into operand fields
 *   Maps funct4 to an operation and flags invalid encodings
 */
module ise_decode
    import ise_pkg::*;
(
    input  logic      cop_insn_valid, // Instruction strobe
    input  word_t     cop_insn_enc,   // Encoded instruction

    output op_t       op,             // Decoded operation
    output cpr_addr_t crd,            // Destination CPR
    output cpr_addr_t crs1,           // First source CPR
    output cpr_addr_t crs2,           // Second source CPR
    output gpr_addr_t rd,             // Destination GPR
    output imm16_t    imm16           // Immediate
);

    logic [6:0] major;  // Major opcode bits
    funct4_t    funct4; // Operation select

    assign major  = cop_insn_enc[6:0];
    assign funct4 = cop_insn_enc[FIELD_FUNCT_LSB +: $bits(funct4_t)];

    // ------------------------------------------------------------------------
    // Field extraction and operation lookup

    always_comb
    begin
        // Idle cycles carry no operands at all
        op    = OP_INVALID;
        crd   = '0;
        crs1  = '0;
        crs2  = '0;
        rd    = '0;
        imm16 = '0;
        if (cop_insn_valid)
        begin
            crd   = cop_insn_enc[FIELD_RD_LSB   +: $bits(cpr_addr_t)];
            crs1  = cop_insn_enc[FIELD_CRS1_LSB +: $bits(cpr_addr_t)];
            crs2  = cop_insn_enc[FIELD_CRS2_LSB +: $bits(cpr_addr_t)];
            rd    = cop_insn_enc[FIELD_RD_LSB   +: $bits(gpr_addr_t)];
            imm16 = cop_insn_enc[FIELD_IMM_LSB  +: $bits(imm16_t)];
            if (major == ISE_MAJOR_OPCODE)
            begin
                case (funct4)
                    FUNCT4_MV2GPR: op = OP_MV2GPR;
                    FUNCT4_MV2COP: op = OP_MV2COP;
                    FUNCT4_CMOV:   op = OP_CMOV;
                    FUNCT4_CMOVN:  op = OP_CMOVN;
                    FUNCT4_LUI:    op = OP_LUI;
                    FUNCT4_LLI:    op = OP_LLI;
                    default:       op = OP_INVALID; // Unused funct4
                endcase
            end
        end
    end

endmodule

// ==== rtl/ise_execute.sv ====
/*
 * Instruction semantics
 *   mv2gpr, mv2cop, cmov.cr, cmovn.cr, lui.cr, lli.cr
 *   CPR write port, GPR write-back, read / written masks, result code
 */
module ise_execute
    import ise_pkg::*;
(
    input  op_t       op,           // Decoded operation
    input  cpr_addr_t crd,
    input  cpr_addr_t crs1,
    input  cpr_addr_t crs2,
    input  gpr_addr_t rd,
    input  imm16_t    imm16,
    input  word_t     cop_rs1,      // GPR source data
    input  word_t     rdata_a,      // CPR[crs1]
    input  word_t     rdata_b,      // CPR[crs2]
    input  word_t     rdata_c,      // CPR[crd]

    output logic      cpr_wen,      // CPR write port
    output cpr_addr_t cpr_waddr,
    output word_t     cpr_wdata,

    output logic      gpr_wen,      // GPR write-back
    output gpr_addr_t gpr_addr,
    output word_t     gpr_data,

    output cpr_mask_t read_mask,    // CPRs read
    output cpr_mask_t written_mask, // CPRs written
    output result_t   result        // Result code
);

    // One bit set at the given CPR index
    function automatic cpr_mask_t cpr_bit(input cpr_addr_t idx);
        cpr_mask_t m;
        m      = '0;
        m[idx] = 1'b1;
        return m;
    endfunction

    logic crs2_zero; // Condition for cmov / cmovn

    assign crs2_zero = (rdata_b == '0);
    assign cpr_waddr = crd; // Every CPR write targets crd

    // ------------------------------------------------------------------------
    // Per-operation behaviour

    always_comb
    begin
        cpr_wen   = 1'b0;
        cpr_wdata = '0;
        gpr_wen   = 1'b0;
        gpr_addr  = '0;    // GPR fields stay zero unless mv2gpr
        gpr_data  = '0;
        read_mask = '0;
        result    = RESULT_SUCCESS;
        case (op)
            OP_MV2GPR:
            begin
                read_mask = cpr_bit(crs1);
                gpr_wen   = 1'b1;
                gpr_addr  = rd;
                gpr_data  = rdata_a;
            end
            OP_MV2COP:
            begin
                cpr_wen   = 1'b1;
                cpr_wdata = cop_rs1;
            end
            OP_CMOV, OP_CMOVN:
            begin
                read_mask = cpr_bit(crs1) | cpr_bit(crs2);
                cpr_wdata = rdata_a;
                // cmov moves on zero, cmovn on non-zero
                cpr_wen   = (op == OP_CMOV) ? crs2_zero : !crs2_zero;
            end
            OP_LUI:
            begin
                read_mask = cpr_bit(crd);
                cpr_wen   = 1'b1;
                cpr_wdata = {imm16, rdata_c[15:0]};  // Keep low half
            end
            OP_LLI:
            begin
                read_mask = cpr_bit(crd);
                cpr_wen   = 1'b1;
                cpr_wdata = {rdata_c[31:16], imm16}; // Keep high half
            end
            default:
            begin
                result = RESULT_DECODE_EXCEPTION; // No writes, empty masks
            end
        endcase
    end

    // Only the crd bit, and only when a write really happens
    assign written_mask = cpr_wen ? cpr_bit(crd) : '0;

endmodule

// ==== rtl/ise_pkg.sv ====
/*
 * Shared definitions of the crypto ISE coprocessor core
 *   Vector typedefs for data words, register indices and masks
 *   Result and operation codes
 *   Instruction encoding field positions and funct4 values
 */
package ise_pkg;

    // ------------------------------------------------------------------------
    // Types

    typedef logic [31:0] word_t;     // GPR / CPR data and instruction word
    typedef logic [ 3:0] cpr_addr_t; // Coprocessor register index
    typedef logic [ 4:0] gpr_addr_t; // General register index
    typedef logic [15:0] cpr_mask_t; // One bit per CPR
    typedef logic [15:0] imm16_t;    // Immediate for lui.cr / lli.cr
    typedef logic [ 2:0] result_t;   // Per-instruction result code
    typedef logic [ 2:0] op_t;       // Decoded operation
    typedef logic [ 3:0] funct4_t;   // Operation select field

    // ------------------------------------------------------------------------
    // Result codes

    localparam result_t RESULT_SUCCESS          = 3'd0;
    localparam result_t RESULT_DECODE_EXCEPTION = 3'd2;

    // Decoded operations
    localparam op_t OP_MV2GPR  = 3'd0;
    localparam op_t OP_MV2COP  = 3'd1;
    localparam op_t OP_CMOV    = 3'd2;
    localparam op_t OP_CMOVN   = 3'd3;
    localparam op_t OP_LUI     = 3'd4;
    localparam op_t OP_LLI     = 3'd5;
    localparam op_t OP_INVALID = 3'd7; // Bad major opcode, unused funct4 or idle

    // ------------------------------------------------------------------------
    // Encoding

    localparam logic [6:0] ISE_MAJOR_OPCODE = 7'b0001011; // custom-0

    // Field start bits
    localparam int FIELD_RD_LSB    = 7;  // rd 11..7, crd 10..7
    localparam int FIELD_IMM_LSB   = 12; // imm16 27..12
    localparam int FIELD_CRS1_LSB  = 15; // crs1 18..15
    localparam int FIELD_CRS2_LSB  = 20; // crs2 23..20
    localparam int FIELD_FUNCT_LSB = 28; // funct4 31..28

    // funct4 values, anything above 5 is unused
    localparam funct4_t FUNCT4_MV2GPR = 4'd0;
    localparam funct4_t FUNCT4_MV2COP = 4'd1;
    localparam funct4_t FUNCT4_CMOV   = 4'd2;
    localparam funct4_t FUNCT4_CMOVN  = 4'd3;
    localparam funct4_t FUNCT4_LUI    = 4'd4;
    localparam funct4_t FUNCT4_LLI    = 4'd5;

    localparam int NUM_CPRS = 16;

endpackage

// ==== rtl/ise_writeback.sv ====
/*
 * Result registers
 *   Captures result, masks and GPR write-back on each valid cycle
 *   Holds them until the next valid instruction
 */
module ise_writeback
    import ise_pkg::*;
(
    input  logic      g_clk,            // Clock
    input  logic      g_resetn,         // Synchronous active low reset
    input  logic      cop_insn_valid,   // Load enable

    input  logic      gpr_wen,          // Next values from execute
    input  gpr_addr_t gpr_addr,
    input  word_t     gpr_data,
    input  cpr_mask_t read_mask,
    input  cpr_mask_t written_mask,
    input  result_t   result,

    output result_t   cop_result,       // Instruction result
    output cpr_mask_t cop_cprs_read,    // CPRs read by instruction
    output cpr_mask_t cop_cprs_written, // CPRs written by instruction
    output logic      cop_rd_wen,       // GPR write enable
    output gpr_addr_t cop_rd_addr,      // GPR write index
    output word_t     cop_rd_data       // GPR write data
);

    // ------------------------------------------------------------------------
    // All outputs load together, one edge after sampling

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            cop_result       <= RESULT_SUCCESS;
            cop_cprs_read    <= '0;
            cop_cprs_written <= '0;
            cop_rd_wen       <= 1'b0;
            cop_rd_addr      <= '0;
            cop_rd_data      <= '0;
        end
        else if (cop_insn_valid)
        begin
            cop_result       <= result;
            cop_cprs_read    <= read_mask;
            cop_cprs_written <= written_mask;
            cop_rd_wen       <= gpr_wen;
            cop_rd_addr      <= gpr_addr;   // Zero unless mv2gpr
            cop_rd_data      <= gpr_data;
        end
        // Idle cycles hold the last instruction's results
    end

endmodule

// ==== verif/ise_sva.sv ====
/*
 * Output assertions for the coprocessor core
 *   GPR write-back, written mask, decode exceptions, idle hold
 *   Bound to ise_cop_top
 */
module ise_sva
    import ise_pkg::*;
(
    input logic      g_clk,
    input logic      g_resetn,
    input logic      cop_insn_valid,
    input result_t   cop_result,
    input cpr_mask_t cop_cprs_read,
    input cpr_mask_t cop_cprs_written,
    input logic      cop_rd_wen,
    input gpr_addr_t cop_rd_addr,
    input word_t     cop_rd_data
);

    int unsigned fail_count = 0; // Failed assertions so far

    // ------------------------------------------------------------------------
    // mv2gpr always reads its source CPR
    a_rd_wen_reads: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_rd_wen |-> (cop_cprs_read != '0))
        else
        begin
            fail_count++;
            $error("GPR write-back without a CPR read");
        end

    // Only crd is ever written
    a_one_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $onehot0(cop_cprs_written))
        else
        begin
            fail_count++;
            $error("More than one CPR written");
        end

    a_exception_clean: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cop_result == RESULT_DECODE_EXCEPTION) |->
            (cop_cprs_read == '0 && cop_cprs_written == '0 && !cop_rd_wen))
        else
        begin
            fail_count++;
            $error("Decode exception with side effects");
        end

    // Idle cycles hold every output
    a_idle_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !cop_insn_valid |=> $stable({cop_result, cop_cprs_read, cop_cprs_written,
                                     cop_rd_wen, cop_rd_addr, cop_rd_data}))
        else
        begin
            fail_count++;
            $error("Outputs changed after an idle cycle");
        end

endmodule

bind ise_cop_top ise_sva u_sva (
    .g_clk            (g_clk),
    .g_resetn         (g_resetn),
    .cop_insn_valid   (cop_insn_valid),
    .cop_result       (cop_result),
    .cop_cprs_read    (cop_cprs_read),
    .cop_cprs_written (cop_cprs_written),
    .cop_rd_wen       (cop_rd_wen),
    .cop_rd_addr      (cop_rd_addr),
    .cop_rd_data      (cop_rd_data)
);

// ==== verif/tb_ise.sv ====
/*
 * Testbench for the crypto ISE coprocessor core
 *   Clock, reset and LFSR random stimulus
 *   CPR reference model with per-cycle output checks
 */
module tb_ise
    import ise_pkg::*;
();

    localparam word_t       RESET_VALUE  = 32'hc0de_5a01; // Seen in mv2gpr reads
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_RANDOM   = 2000;          // Valid random instructions
    localparam int          MAX_CYCLES   = RESET_CYCLES + 2 * NUM_RANDOM + 200; // 200 directed
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic        g_clk = 1'b0;
    logic        g_resetn;
    logic        cop_insn_valid;
    word_t       cop_insn_enc;
    word_t       cop_rs1;
    result_t     cop_result;
    cpr_mask_t   cop_cprs_read;
    cpr_mask_t   cop_cprs_written;
    logic        cop_rd_wen;
    gpr_addr_t   cop_rd_addr;
    word_t       cop_rd_data;

    word_t       cpr_model [NUM_CPRS]; // Reference CPR state
    result_t     exp_result;           // Predicted outputs
    cpr_mask_t   exp_read;
    cpr_mask_t   exp_written;
    logic        exp_rd_wen;
    gpr_addr_t   exp_rd_addr;
    word_t       exp_rd_data;
    logic [31:0] lfsr = 32'h19a9_1dab;
    int          cycle_count = 0;
    int          error_count = 0;
    int          insn_count  = 0;

    ise_cop_top #(.CPR_RESET_VALUE (RESET_VALUE)) dut0 (.*);

    always #4 g_clk = ~g_clk; // 8 unit period

    // ------------------------------------------------------------------------
    // Run limit
    always @(posedge g_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout, instruction stream still running after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // Next n LFSR bits, one step per bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("FAIL at %0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Register form, rd or crd in 11..7
    function automatic word_t encode(input logic [3:0] funct4, input logic [4:0] rd,
                                     input cpr_addr_t crs1, input cpr_addr_t crs2);
        return {funct4, 4'h0, crs2, 1'b0, crs1, 3'b000, rd, ISE_MAJOR_OPCODE};
    endfunction

    // ------------------------------------------------------------------------
    // Reference semantics of one valid instruction
    task automatic apply_model(input word_t enc, input word_t rs1);
        cpr_addr_t crd;
        cpr_addr_t crs1;
        cpr_addr_t crs2;
        word_t     value;
        logic      move;
        crd         = enc[10:7];
        crs1        = enc[18:15];
        crs2        = enc[23:20];
        value       = '0;
        move        = 1'b0;
        exp_result  = RESULT_SUCCESS;
        exp_read    = '0;
        exp_written = '0;
        exp_rd_wen  = 1'b0;
        exp_rd_addr = '0;
        exp_rd_data = '0;
        if (enc[6:0] != ISE_MAJOR_OPCODE || enc[31:28] > 4'd5)
        begin
            exp_result = RESULT_DECODE_EXCEPTION; // Nothing read or written
        end
        else
        begin
            case (enc[31:28])
                4'd0: // mv2gpr
                begin
                    exp_read[crs1] = 1'b1;
                    exp_rd_wen     = 1'b1;
                    exp_rd_addr    = enc[11:7];
                    exp_rd_data    = cpr_model[crs1];
                end
                4'd1: // mv2cop
                begin
                    value = rs1;
                    move  = 1'b1;
                end
                4'd2, 4'd3: // cmov on zero, cmovn on non-zero
                begin
                    exp_read[crs1] = 1'b1;
                    exp_read[crs2] = 1'b1;
                    value          = cpr_model[crs1];
                    move           = (cpr_model[crs2] == 32'd0) == (enc[31:28] == 4'd2);
                end
                default: // lui / lli merge into old crd
                begin
                    exp_read[crd] = 1'b1;
                    value = (enc[31:28] == 4'd4) ? {enc[27:12], cpr_model[crd][15:0]}
                                                 : {cpr_model[crd][31:16], enc[27:12]};
                    move  = 1'b1;
                end
            endcase
        end
        if (move)
        begin
            exp_written[crd] = 1'b1;
            cpr_model[crd]   = value; // Seen by the next instruction
        end
    endtask

    // Drive one cycle, check the registered outputs after the next edge
    task automatic step_cycle(input logic valid, input word_t enc, input word_t rs1);
        cop_insn_valid = valid;
        cop_insn_enc   = enc;
        cop_rs1        = rs1;
        if (valid)
        begin
            apply_model(enc, rs1);
        end
        @(posedge g_clk);
        #1;                                  // Settled outputs, next drive point
        check_value("cop_result",       32'(exp_result),  32'(cop_result));
        check_value("cop_cprs_read",    32'(exp_read),    32'(cop_cprs_read));
        check_value("cop_cprs_written", 32'(exp_written), 32'(cop_cprs_written));
        check_value("cop_rd_wen",       32'(exp_rd_wen),  32'(cop_rd_wen));
        check_value("cop_rd_addr",      32'(exp_rd_addr), 32'(cop_rd_addr));
        check_value("cop_rd_data",      exp_rd_data,      cop_rd_data);
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        logic        valid;
        word_t       enc;
        word_t       rs1;
        take_bits(2, r);
        valid = (r[1:0] != 2'b00);           // About 3 in 4 cycles valid
        take_bits(32, enc);                  // funct4, fields and immediate
        take_bits(2, r);
        if (r[1:0] != 2'b00)
        begin
            enc[10] = 1'b0;                  // Small CPR set 0..7
            enc[18] = 1'b0;
            enc[23] = 1'b0;
        end
        take_bits(3, r);
        if (r[2:0] != 3'b000)
        begin
            enc[6:0] = ISE_MAJOR_OPCODE;
        end
        else if (enc[6:0] == ISE_MAJOR_OPCODE)
        begin
            enc[0] = ~enc[0];                // Keep a wrong major opcode wrong
        end
        take_bits(2, r);
        if (r[1:0] == 2'b00)
        begin
            rs1 = '0;                        // Zero CPRs for the cmov conditions
        end
        else
        begin
            take_bits(32, rs1);
        end
        step_cycle(valid, enc, rs1);
    endtask

    // ------------------------------------------------------------------------
    initial
    begin
        g_resetn       = 1'b0;
        cop_insn_valid = 1'b0;
        cop_insn_enc   = '0;
        cop_rs1        = '0;
        exp_result     = RESULT_SUCCESS;
        exp_read       = '0;
        exp_written    = '0;
        exp_rd_wen     = 1'b0;
        exp_rd_addr    = '0;
        exp_rd_data    = '0;
        for (int i = 0; i < NUM_CPRS; i++)
        begin
            cpr_model[i] = RESET_VALUE;
        end
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;

        // Reset outputs, then every CPR reads back its reset value
        step_cycle(1'b0, 32'hffff_ffff, 32'hffff_ffff);
        for (int i = 0; i < NUM_CPRS; i++)
        begin
            step_cycle(1'b1, encode(4'd0, 5'(31 - i), 4'(i), 4'd0), '0);
        end
        check_value("cop_rd_data", RESET_VALUE, cop_rd_data);

        // mv2cop then mv2gpr through CPR 3
        step_cycle(1'b1, encode(4'd1, 5'd3, 4'd0, 4'd0), 32'hdead_beef);
        step_cycle(1'b1, encode(4'd0, 5'd17, 4'd3, 4'd0), '0);

        // cmov / cmovn on a zero (CPR 4) and a non-zero (CPR 6) condition
        step_cycle(1'b1, encode(4'd1, 5'd4, 4'd0, 4'd0), 32'h0);
        step_cycle(1'b1, encode(4'd1, 5'd5, 4'd0, 4'd0), 32'h1234_5678);
        step_cycle(1'b1, encode(4'd1, 5'd6, 4'd0, 4'd0), 32'h0000_0001);
        step_cycle(1'b1, encode(4'd2, 5'd7, 4'd5, 4'd4), '0); // Moves
        step_cycle(1'b1, encode(4'd3, 5'd8, 4'd5, 4'd4), '0); // Stays
        step_cycle(1'b1, encode(4'd2, 5'd9, 4'd5, 4'd6), '0); // Stays
        step_cycle(1'b1, encode(4'd3, 5'd9, 4'd5, 4'd6), '0); // Moves
        check_value("cop_cprs_written", 32'h0000_0200, 32'(cop_cprs_written));
        for (int i = 7; i < 10; i++)
        begin
            step_cycle(1'b1, encode(4'd0, 5'd1, 4'(i), 4'd0), '0);
        end

        // lui.cr then lli.cr back to back on CPR 10
        step_cycle(1'b1, {4'd4, 16'ha5a5, 5'd10, ISE_MAJOR_OPCODE}, '0);
        step_cycle(1'b1, {4'd5, 16'h3c3c, 5'd10, ISE_MAJOR_OPCODE}, '0);
        step_cycle(1'b1, encode(4'd0, 5'd2, 4'd10, 4'd0), '0);
        check_value("cop_rd_data", 32'ha5a5_3c3c, cop_rd_data);

        // Wrong major opcode and unused funct4, CPR 10 must survive
        step_cycle(1'b1, encode(4'd1, 5'd10, 4'd0, 4'd0) ^ 32'h0000_0040, 32'hffff_ffff);
        step_cycle(1'b1, encode(4'd9, 5'd10, 4'd10, 4'd10), 32'hffff_ffff);
        step_cycle(1'b1, encode(4'd15, 5'd10, 4'd10, 4'd10), 32'hffff_ffff);
        step_cycle(1'b1, encode(4'd0, 5'd2, 4'd10, 4'd0), '0);

        // Idle cycles with a live-looking mv2cop on the bus
        repeat (3) step_cycle(1'b0, encode(4'd1, 5'd10, 4'd0, 4'd0), 32'h0bad_0bad);
        step_cycle(1'b1, encode(4'd0, 5'd2, 4'd10, 4'd0), '0);

        while (insn_count < NUM_RANDOM)
        begin
            random_cycle();
            if (cop_insn_valid)
            begin
                insn_count++;
            end
        end
        cop_insn_valid = 1'b0;

        // Bound assertion failures count as errors too
        if (error_count == 0 && dut0.u_sva.fail_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/ise_pkg.sv
rtl/ise_decode.sv
rtl/ise_cpr_file.sv
rtl/ise_execute.sv
rtl/ise_writeback.sv
rtl/ise_cop_top.sv
verif/ise_sva.sv
verif/tb_ise.sv
